/* Bender.yml */
package:
  name: backend

sources:
  - backend_cfg_pkg.sv
  - backend_isa_pkg.sv
  - uop_if.sv
  - arch_regfile.sv
  - idu_decoder.sv
  - issue_queue.sv
  - exu_int.sv
  - backend.sv
  - target: simulation
    files:
      - tb_backend.sv

/* arch_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module arch_regfile (
    input  logic                   clock,
    input  logic                   rst,
    input  backend_cfg_pkg::lreg_t rs1_addr,
    input  backend_cfg_pkg::lreg_t rs2_addr,
    output backend_cfg_pkg::xlen_t rs1_data,
    output backend_cfg_pkg::xlen_t rs2_data,
    input  logic                   we,
    input  backend_cfg_pkg::lreg_t wr_addr,
    input  backend_cfg_pkg::xlen_t wr_data
);
    import backend_cfg_pkg::*;

    xlen_t regs [1:31];  // no storage for x0

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* backend.sv */
`timescale 1ns/1ps
`default_nettype none

module backend #(
    parameter int QUEUE_DEPTH = backend_cfg_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  logic                    clock,
    input  logic                    rst,

    input  logic                    ibuffer_instr_valid,
    output logic                    ibuffer_instr_ready,
    input  backend_cfg_pkg::instr_t ibuffer_inst_out,
    input  backend_cfg_pkg::pc_t    ibuffer_pc_out,

    output logic                    wb_valid,
    output backend_cfg_pkg::pc_t    wb_pc,
    output backend_cfg_pkg::lreg_t  wb_rd,
    output backend_cfg_pkg::xlen_t  wb_result
);

    uop_if dec_uop ();  // decoder -> queue
    uop_if iss_uop ();  // queue -> execute

    idu_decoder u_idu_decoder (
        .clock              (clock),
        .rst                (rst),
        .ibuffer_instr_valid(ibuffer_instr_valid),
        .ibuffer_instr_ready(ibuffer_instr_ready),
        .ibuffer_inst_out   (ibuffer_inst_out),
        .ibuffer_pc_out     (ibuffer_pc_out),
        .uop                (dec_uop.producer)
    );

    issue_queue #(
        .DEPTH(QUEUE_DEPTH)
    ) u_issue_queue (
        .clock(clock),
        .rst  (rst),
        .enq  (dec_uop.consumer),
        .deq  (iss_uop.producer)
    );

    exu_int u_exu_int (
        .clock    (clock),
        .rst      (rst),
        .uop      (iss_uop.consumer),
        .wb_valid (wb_valid),
        .wb_pc    (wb_pc),
        .wb_rd    (wb_rd),
        .wb_result(wb_result)
    );

endmodule

`default_nettype wire

/* backend_cfg_pkg.sv */
`default_nettype none

package backend_cfg_pkg;

    parameter int XLEN                = 64;  // data word
    parameter int LREG_W              = 5;   // logical register index
    parameter int QUEUE_DEPTH_DEFAULT = 4;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [63:0]       pc_t;
    typedef logic [31:0]       instr_t;
    typedef logic [LREG_W-1:0] lreg_t;

endpackage

`default_nettype wire

/* backend_isa_pkg.sv */
`default_nettype none

package backend_isa_pkg;

    // major opcodes
    parameter logic [6:0] OPC_OP     = 7'b0110011;
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
    parameter logic [6:0] OPC_LUI    = 7'b0110111;
    parameter logic [6:0] OPC_AUIPC  = 7'b0010111;

    parameter logic [2:0] F3_ADD = 3'b000;  // also sub, mul
    parameter logic [2:0] F3_SLL = 3'b001;
    parameter logic [2:0] F3_XOR = 3'b100;
    parameter logic [2:0] F3_SRL = 3'b101;
    parameter logic [2:0] F3_OR  = 3'b110;
    parameter logic [2:0] F3_AND = 3'b111;

    parameter logic [6:0] F7_BASE = 7'b0000000;
    parameter logic [6:0] F7_SUB  = 7'b0100000;
    parameter logic [6:0] F7_MUL  = 7'b0000001;  // M extension

    typedef enum logic [7:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS,    // lui
        ALU_PC_ADD,  // auipc
        ALU_MUL
    } alu_op_e;

    typedef enum logic {
        EXU_IDLE,
        EXU_MUL_BUSY
    } exu_state_e;

endpackage

`default_nettype wire

/* compile.f */
backend_cfg_pkg.sv
backend_isa_pkg.sv
uop_if.sv
arch_regfile.sv
idu_decoder.sv
issue_queue.sv
exu_int.sv
backend.sv
tb_backend.sv

/* exu_int.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_int (
    input  logic                   clock,
    input  logic                   rst,
    uop_if.consumer                uop,
    output logic                   wb_valid,
    output backend_cfg_pkg::pc_t   wb_pc,
    output backend_cfg_pkg::lreg_t wb_rd,
    output backend_cfg_pkg::xlen_t wb_result
);
    import backend_cfg_pkg::*;
    import backend_isa_pkg::*;

    localparam int              CNT_W    = $clog2(XLEN);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(XLEN - 1);

    exu_state_e       state;
    xlen_t            rs1_data;
    xlen_t            rs2_data;
    xlen_t            src2;
    xlen_t            alu_result;
    logic             accept;
    logic             alu_fire;
    logic             mul_start;
    logic             mul_done;
    logic             rf_we;
    lreg_t            rf_waddr;
    xlen_t            rf_wdata;
    logic [CNT_W-1:0] mul_cnt;
    xlen_t            mul_mcand;
    xlen_t            mul_mplier;
    xlen_t            mul_prod;
    xlen_t            mul_sum;
    pc_t              mul_pc;
    lreg_t            mul_rd;
    logic             mul_wb;

    arch_regfile u_arch_regfile (
        .clock   (clock),
        .rst     (rst),
        .rs1_addr(uop.rs1),
        .rs2_addr(uop.rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .we      (rf_we),
        .wr_addr (rf_waddr),
        .wr_data (rf_wdata)
    );

    assign uop.ready = (state == EXU_IDLE);
    assign accept    = uop.valid && uop.ready;
    assign mul_start = accept && (uop.alu_op == ALU_MUL);
    assign alu_fire  = accept && (uop.alu_op != ALU_MUL) && uop.need_to_wb;
    assign mul_done  = (state == EXU_MUL_BUSY) && (mul_cnt == CNT_LAST);
    assign src2      = uop.src2_is_imm ? uop.imm : rs2_data;

    always_comb begin
        case (uop.alu_op)
            ALU_ADD:    alu_result = rs1_data + src2;
            ALU_SUB:    alu_result = rs1_data - src2;
            ALU_AND:    alu_result = rs1_data & src2;
            ALU_OR:     alu_result = rs1_data | src2;
            ALU_XOR:    alu_result = rs1_data ^ src2;
            ALU_SLL:    alu_result = rs1_data << src2[5:0];
            ALU_SRL:    alu_result = rs1_data >> src2[5:0];
            ALU_PASS:   alu_result = uop.imm;
            ALU_PC_ADD: alu_result = uop.pc + uop.imm;
            default:    alu_result = '0;  // mul goes through the iterative path
        endcase
    end

    // one shift-add step per busy cycle
    assign mul_sum = mul_prod + (mul_mplier[0] ? mul_mcand : '0);

    // alu and mul writes never overlap
    assign rf_we    = alu_fire || (mul_done && mul_wb);
    assign rf_waddr = alu_fire ? uop.rd : mul_rd;
    assign rf_wdata = alu_fire ? alu_result : mul_sum;

    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= EXU_IDLE;
            mul_cnt  <= '0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= rf_we;
            if (mul_start) begin
                state   <= EXU_MUL_BUSY;
                mul_cnt <= '0;
            end else if (mul_done) begin
                state <= EXU_IDLE;
            end else if (state == EXU_MUL_BUSY) begin
                mul_cnt <= mul_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (mul_start) begin
            mul_mcand  <= rs1_data;  // operands latched at acceptance
            mul_mplier <= src2;
            mul_prod   <= '0;
            mul_pc     <= uop.pc;
            mul_rd     <= uop.rd;
            mul_wb     <= uop.need_to_wb;
        end else if (state == EXU_MUL_BUSY) begin
            mul_prod   <= mul_sum;
            mul_mcand  <= mul_mcand << 1;
            mul_mplier <= mul_mplier >> 1;
        end
        if (rf_we) begin
            wb_pc     <= alu_fire ? uop.pc : mul_pc;
            wb_rd     <= rf_waddr;
            wb_result <= rf_wdata;
        end
    end

endmodule

`default_nettype wire

/* idu_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module idu_decoder (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    ibuffer_instr_valid,
    output logic                    ibuffer_instr_ready,
    input  backend_cfg_pkg::instr_t ibuffer_inst_out,
    input  backend_cfg_pkg::pc_t    ibuffer_pc_out,
    uop_if.producer                 uop
);
    import backend_cfg_pkg::*;
    import backend_isa_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    lreg_t      rd;
    logic       supported;
    logic       keep;
    logic       accept;
    alu_op_e    dec_op;
    xlen_t      dec_imm;
    logic       dec_src2_imm;

    assign opcode = ibuffer_inst_out[6:0];
    assign funct3 = ibuffer_inst_out[14:12];
    assign funct7 = ibuffer_inst_out[31:25];
    assign rd     = ibuffer_inst_out[11:7];

    always_comb begin
        supported    = 1'b0;
        dec_op       = ALU_ADD;
        dec_imm      = '0;
        dec_src2_imm = 1'b0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_MUL) begin
                    supported = (funct3 == F3_ADD);
                    dec_op    = ALU_MUL;
                end else if (funct7 == F7_SUB) begin
                    supported = (funct3 == F3_ADD);  // sra not kept
                    dec_op    = ALU_SUB;
                end else if (funct7 == F7_BASE) begin
                    supported = 1'b1;
                    case (funct3)
                        F3_ADD:  dec_op = ALU_ADD;
                        F3_SLL:  dec_op = ALU_SLL;
                        F3_XOR:  dec_op = ALU_XOR;
                        F3_SRL:  dec_op = ALU_SRL;
                        F3_OR:   dec_op = ALU_OR;
                        F3_AND:  dec_op = ALU_AND;
                        default: supported = 1'b0;  // slt/sltu
                    endcase
                end
            end
            OPC_OP_IMM: begin
                supported    = 1'b1;
                dec_src2_imm = 1'b1;
                dec_imm      = {{(XLEN-12){ibuffer_inst_out[31]}}, ibuffer_inst_out[31:20]};
                case (funct3)
                    F3_ADD:  dec_op = ALU_ADD;
                    F3_XOR:  dec_op = ALU_XOR;
                    F3_OR:   dec_op = ALU_OR;
                    F3_AND:  dec_op = ALU_AND;
                    default: supported = 1'b0;
                endcase
            end
            OPC_LUI, OPC_AUIPC: begin
                supported    = 1'b1;
                dec_src2_imm = 1'b1;
                dec_op       = (opcode == OPC_LUI) ? ALU_PASS : ALU_PC_ADD;
                dec_imm      = {{(XLEN-32){ibuffer_inst_out[31]}}, ibuffer_inst_out[31:12], 12'b0};
            end
            default: supported = 1'b0;
        endcase
    end

    assign keep                = supported && (rd != '0);  // bubbles and x0 writes vanish here
    assign ibuffer_instr_ready = !uop.valid || uop.ready;
    assign accept              = ibuffer_instr_valid && ibuffer_instr_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            uop.valid <= 1'b0;
        end else if (accept) begin
            uop.valid <= keep;
        end else if (uop.ready) begin
            uop.valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept && keep) begin
            uop.alu_op      <= dec_op;
            uop.pc          <= ibuffer_pc_out;
            uop.rd          <= rd;
            uop.rs1         <= ibuffer_inst_out[19:15];
            uop.rs2         <= ibuffer_inst_out[24:20];
            uop.imm         <= dec_imm;
            uop.src2_is_imm <= dec_src2_imm;
            uop.need_to_wb  <= keep;
        end
    end

endmodule

`default_nettype wire

/* issue_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_queue #(
    parameter int DEPTH = 4
) (
    input  logic    clock,
    input  logic    rst,
    uop_if.consumer enq,
    uop_if.producer deq
);
    import backend_cfg_pkg::*;
    import backend_isa_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    alu_op_e q_alu_op   [DEPTH];
    pc_t     q_pc       [DEPTH];
    lreg_t   q_rd       [DEPTH];
    lreg_t   q_rs1      [DEPTH];
    lreg_t   q_rs2      [DEPTH];
    xlen_t   q_imm      [DEPTH];
    logic    q_src2_imm [DEPTH];
    logic    q_need_wb  [DEPTH];

    logic [IDX_W:0]   wr_ptr;  // extra msb separates full from empty
    logic [IDX_W:0]   rd_ptr;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             full;
    logic             empty;

    assign wr_idx = wr_ptr[IDX_W-1:0];
    assign rd_idx = rd_ptr[IDX_W-1:0];
    assign empty  = (wr_ptr == rd_ptr);
    assign full   = (wr_ptr[IDX_W] != rd_ptr[IDX_W]) && (wr_idx == rd_idx);

    assign enq.ready = !full;
    assign deq.valid = !empty;

    // oldest entry sits at the head
    assign deq.alu_op      = q_alu_op[rd_idx];
    assign deq.pc          = q_pc[rd_idx];
    assign deq.rd          = q_rd[rd_idx];
    assign deq.rs1         = q_rs1[rd_idx];
    assign deq.rs2         = q_rs2[rd_idx];
    assign deq.imm         = q_imm[rd_idx];
    assign deq.src2_is_imm = q_src2_imm[rd_idx];
    assign deq.need_to_wb  = q_need_wb[rd_idx];

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (enq.valid && enq.ready) wr_ptr <= wr_ptr + 1'b1;
            if (deq.valid && deq.ready) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (enq.valid && enq.ready) begin
            q_alu_op[wr_idx]   <= enq.alu_op;
            q_pc[wr_idx]       <= enq.pc;
            q_rd[wr_idx]       <= enq.rd;
            q_rs1[wr_idx]      <= enq.rs1;
            q_rs2[wr_idx]      <= enq.rs2;
            q_imm[wr_idx]      <= enq.imm;
            q_src2_imm[wr_idx] <= enq.src2_is_imm;
            q_need_wb[wr_idx]  <= enq.need_to_wb;
        end
    end

endmodule

`default_nettype wire

/* tb_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_backend;
    import backend_cfg_pkg::*;

    localparam int          N_SEED     = 62;
    localparam int          N_RR       = 40;
    localparam int          N_CHAIN    = 16;
    localparam int          N_IMM      = 48;
    localparam int          N_X0       = 40;
    localparam int          N_MUL      = 24;
    localparam int          N_STREAM   = 200;
    localparam int          N_TOTAL    = N_SEED + N_RR + N_CHAIN + N_IMM + N_X0 + N_MUL + N_STREAM;
    localparam longint      TIMEOUT_NS = longint'(N_TOTAL) * (XLEN + 8) * 4;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

    typedef enum int {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLL, K_SRL,
        K_ADDI, K_ANDI, K_ORI, K_XORI, K_LUI, K_AUIPC, K_MUL, K_BAD
    } kind_e;

    logic   clock = 1'b0;
    logic   rst;
    logic   ibuffer_instr_valid;
    logic   ibuffer_instr_ready;
    instr_t ibuffer_inst_out;
    pc_t    ibuffer_pc_out;
    logic   wb_valid;
    pc_t    wb_pc;
    lreg_t  wb_rd;
    xlen_t  wb_result;

    logic [31:0] lfsr;
    xlen_t       model_regs [32];
    pc_t         exp_pc [$];
    lreg_t       exp_rd [$];
    xlen_t       exp_res [$];
    pc_t         cur_pc;
    pc_t         head_pc;
    lreg_t       head_rd;
    xlen_t       head_res;
    int          errors;
    int          checks;
    int          base_errors;
    int          base_checks;
    int          stall_cycles;

    backend #(
        .QUEUE_DEPTH(QUEUE_DEPTH_DEFAULT)
    ) dut0 (
        .clock              (clock),
        .rst                (rst),
        .ibuffer_instr_valid(ibuffer_instr_valid),
        .ibuffer_instr_ready(ibuffer_instr_ready),
        .ibuffer_inst_out   (ibuffer_inst_out),
        .ibuffer_pc_out     (ibuffer_pc_out),
        .wb_valid           (wb_valid),
        .wb_pc              (wb_pc),
        .wb_rd              (wb_rd),
        .wb_result          (wb_result)
    );

    always #2 clock = ~clock;

    // one lfsr step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic lreg_t rnd_reg();
        return lreg_t'(rand_bits(5));
    endfunction

    function automatic lreg_t nz_reg();
        return lreg_t'(1 + rand_bits(8) % 31);
    endfunction

    function automatic kind_e rr_kind();
        return kind_e'(rand_bits(8) % 7);
    endfunction

    function automatic kind_e imm_kind();
        return kind_e'(K_ADDI + rand_bits(8) % 6);
    endfunction

    function automatic pc_t step_pc();
        cur_pc = cur_pc + 4;
        return cur_pc;
    endfunction

    function automatic instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                     input lreg_t rd, input lreg_t rs1, input lreg_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic instr_t enc_i(input logic [2:0] f3, input lreg_t rd, input lreg_t rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic instr_t encode(input kind_e kind, input lreg_t rd, input lreg_t rs1,
                                      input lreg_t rs2, input logic [11:0] imm12,
                                      input logic [19:0] imm20, input logic [24:0] filler);
        case (kind)
            K_ADD:   return enc_r(7'h00, 3'h0, rd, rs1, rs2);
            K_SUB:   return enc_r(7'h20, 3'h0, rd, rs1, rs2);
            K_AND:   return enc_r(7'h00, 3'h7, rd, rs1, rs2);
            K_OR:    return enc_r(7'h00, 3'h6, rd, rs1, rs2);
            K_XOR:   return enc_r(7'h00, 3'h4, rd, rs1, rs2);
            K_SLL:   return enc_r(7'h00, 3'h1, rd, rs1, rs2);
            K_SRL:   return enc_r(7'h00, 3'h5, rd, rs1, rs2);
            K_ADDI:  return enc_i(3'h0, rd, rs1, imm12);
            K_ANDI:  return enc_i(3'h7, rd, rs1, imm12);
            K_ORI:   return enc_i(3'h6, rd, rs1, imm12);
            K_XORI:  return enc_i(3'h4, rd, rs1, imm12);
            K_LUI:   return {imm20, rd, 7'b0110111};
            K_AUIPC: return {imm20, rd, 7'b0010111};
            K_MUL:   return enc_r(7'h01, 3'h0, rd, rs1, rs2);
            default: begin
                case (filler[1:0])
                    2'd0:    return {filler, 7'b0000011};          // load
                    2'd1:    return enc_r(7'h00, 3'h2, rd, rs1, rs2);  // slt
                    2'd2:    return enc_r(7'h20, 3'h5, rd, rs1, rs2);  // sra
                    default: return {filler, 7'b1100011};          // branch
                endcase
            end
        endcase
    endfunction

    function automatic xlen_t model_result(input kind_e kind, input xlen_t a, input xlen_t b,
                                           input xlen_t simm, input xlen_t uimm, input pc_t pc);
        case (kind)
            K_ADD:   return a + b;
            K_SUB:   return a - b;
            K_AND:   return a & b;
            K_OR:    return a | b;
            K_XOR:   return a ^ b;
            K_SLL:   return a << b[5:0];
            K_SRL:   return a >> b[5:0];
            K_ADDI:  return a + simm;
            K_ANDI:  return a & simm;
            K_ORI:   return a | simm;
            K_XORI:  return a ^ simm;
            K_LUI:   return uimm;
            K_AUIPC: return pc + uimm;
            K_MUL:   return a * b;  // low 64 bits
            default: return '0;
        endcase
    endfunction

    // returns on the falling edge after the transfer
    task automatic send(input instr_t ins, input pc_t pc, input int idle);
        repeat (idle) @(negedge clock);
        ibuffer_instr_valid = 1'b1;
        ibuffer_inst_out    = ins;
        ibuffer_pc_out      = pc;
        while (!ibuffer_instr_ready) begin
            stall_cycles++;
            @(negedge clock);
        end
        @(negedge clock);
        ibuffer_instr_valid = 1'b0;
    endtask

    task automatic run_instr(input kind_e kind, input lreg_t rd, input lreg_t rs1,
                             input lreg_t rs2, input pc_t pc, input int idle);
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [24:0] filler;
        xlen_t       simm;
        xlen_t       uimm;
        xlen_t       res;
        imm12  = 12'(rand_bits(12));
        imm20  = 20'(rand_bits(20));
        filler = 25'(rand_bits(25));
        simm   = {{(XLEN-12){imm12[11]}}, imm12};
        uimm   = {{(XLEN-32){imm20[19]}}, imm20, 12'b0};
        res    = model_result(kind, model_regs[rs1], model_regs[rs2], simm, uimm, pc);
        send(encode(kind, rd, rs1, rs2, imm12, imm20, filler), pc, idle);
        if (rd != '0 && kind != K_BAD) begin
            model_regs[rd] = res;
            exp_pc.push_back(pc);
            exp_rd.push_back(rd);
            exp_res.push_back(res);
        end
    endtask

    task automatic start_test();
        base_errors = errors;
        base_checks = checks;
    endtask

    task automatic finish_test(input string name);
        while (exp_pc.size() != 0) @(negedge clock);
        repeat (4) @(negedge clock);  // room for a stray pulse
        $display("%s: %0d writebacks checked, %0d errors", name, checks - base_checks,
                 errors - base_errors);
    endtask

    always @(negedge clock) begin
        if (!rst && wb_valid) begin
            assert (exp_pc.size() != 0) else begin
                $display("writeback from pc %h at %0t with no instruction pending", wb_pc, $time);
                errors++;
            end
            if (exp_pc.size() != 0) begin
                head_pc  = exp_pc.pop_front();
                head_rd  = exp_rd.pop_front();
                head_res = exp_res.pop_front();
                checks++;
                assert (wb_pc == head_pc) else begin
                    $display("ERR %0t: wb_pc %h, expected %h", $time, wb_pc, head_pc);
                    errors++;
                end
                assert (wb_rd == head_rd) else begin
                    $display("ERR %0t: wb_rd %0d, expected %0d", $time, wb_rd, head_rd);
                    errors++;
                end
                assert (wb_result == head_res) else begin
                    $display("ERR %0t: result %h, expected %h", $time, wb_result, head_res);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns, writebacks still missing", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        lreg_t prev;
        lreg_t rd;
        lfsr                = 32'd84661;
        rst                 = 1'b1;
        ibuffer_instr_valid = 1'b0;
        ibuffer_inst_out    = '0;
        ibuffer_pc_out      = '0;
        errors              = 0;
        checks              = 0;
        stall_cycles        = 0;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        cur_pc = pc_t'(rand_bits(40)) << 2;
        repeat (4) @(negedge clock);
        rst = 1'b0;

        start_test();
        for (int r = 1; r < 32; r++) begin  // fill every register first
            run_instr(K_LUI, lreg_t'(r), '0, '0, step_pc(), 0);
            run_instr(K_XORI, lreg_t'(r), lreg_t'(r), '0, step_pc(), 0);
        end
        for (int i = 0; i < N_RR; i++) begin
            run_instr(rr_kind(), rnd_reg(), rnd_reg(), rnd_reg(), step_pc(), 0);
        end
        prev = nz_reg();
        for (int i = 0; i < N_CHAIN; i++) begin
            rd = nz_reg();
            run_instr(rr_kind(), rd, prev, rnd_reg(), step_pc(), 0);
            prev = rd;
        end
        finish_test("register-register alu");

        start_test();
        for (int i = 0; i < N_IMM; i++) begin
            run_instr(imm_kind(), rnd_reg(), rnd_reg(), '0, pc_t'(rand_bits(62)) << 2, 0);
        end
        finish_test("immediate and upper-immediate");

        start_test();
        for (int i = 0; i < N_X0; i++) begin
            case (rand_bits(2))
                0:       run_instr(kind_e'(rand_bits(8) % 14), '0, rnd_reg(), rnd_reg(),
                                   step_pc(), 0);
                1:       run_instr(K_BAD, rnd_reg(), rnd_reg(), rnd_reg(), step_pc(), 0);
                2:       run_instr(kind_e'(rand_bits(8) % 14), nz_reg(), '0, '0, step_pc(), 0);
                default: run_instr(rr_kind(), nz_reg(), rnd_reg(), rnd_reg(), step_pc(), 0);
            endcase
        end
        finish_test("x0 and unsupported encodings");

        start_test();
        stall_cycles = 0;
        for (int i = 0; i < N_MUL; i++) begin
            run_instr(rand_bits(2) != 0 ? K_MUL : rr_kind(), nz_reg(), rnd_reg(), rnd_reg(),
                      step_pc(), 0);
        end
        assert (stall_cycles > 0) else begin
            $display("ibuffer_instr_ready never dropped during the multiply burst");
            errors++;
        end
        finish_test("multiply burst");

        start_test();
        for (int i = 0; i < N_STREAM; i++) begin
            run_instr(kind_e'(rand_bits(8) % 15), rnd_reg(), rnd_reg(), rnd_reg(), step_pc(),
                      int'(rand_bits(2)));
        end
        finish_test("random stream");

        $display("5 tests, %0d writebacks checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* uop_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface uop_if;
    import backend_cfg_pkg::*;
    import backend_isa_pkg::*;

    logic    valid;
    logic    ready;
    alu_op_e alu_op;
    pc_t     pc;
    lreg_t   rd;
    lreg_t   rs1;
    lreg_t   rs2;
    xlen_t   imm;
    logic    src2_is_imm;
    logic    need_to_wb;

    modport producer (
        output valid, alu_op, pc, rd, rs1, rs2, imm, src2_is_imm, need_to_wb,
        input  ready
    );

    modport consumer (
        input  valid, alu_op, pc, rd, rs1, rs2, imm, src2_is_imm, need_to_wb,
        output ready
    );

endinterface

`default_nettype wire
